//--- scoreboard_cpu_pkg.sv
`default_nettype none

package scoreboard_cpu_pkg;

    // Architectural sizes
    localparam int NUM_REG     = 16;
    localparam int DATA_W      = 16;
    localparam int PC_W        = 8;
    localparam int ID_W        = 8;
    localparam int IMM_W       = 8;

    // Multiplier latency, also the number of multiplies that can be in flight
    localparam int MUL_STAGES  = 3;

    localparam int STORE_DEPTH = 4;

    // Derived widths
    localparam int REG_ID_W    = $clog2(NUM_REG);
    localparam int SQ_PTR_W    = $clog2(STORE_DEPTH);
    localparam int SQ_CNT_W    = $clog2(STORE_DEPTH + 1);

    typedef logic [DATA_W-1:0]   data_t;
    typedef logic [REG_ID_W-1:0] reg_id_t;
    typedef logic [PC_W-1:0]     pc_t;
    typedef logic [ID_W-1:0]     inst_id_t;
    typedef logic [IMM_W-1:0]    imm_t;

    // One bit per architectural register
    typedef logic [NUM_REG-1:0]  reg_mask_t;

    typedef enum logic [2:0] {
        OP_ST      = 3'd0,
        OP_CMP_GT  = 3'd1,
        OP_ADD_IMM = 3'd2,
        OP_ADD     = 3'd3,
        OP_SHL     = 3'd4,
        OP_SHR     = 3'd5,
        OP_MUL     = 3'd6,
        OP_BZ      = 3'd7
    } op_t;

endpackage

`default_nettype wire

//--- scoreboard_cpu_if.sv
`default_nettype none

// Dispatch from the issue stage into the ALU and the multiplier
interface issue_if;
    import scoreboard_cpu_pkg::*;

    logic    alu_vld;
    logic    mul_vld;
    op_t     op;
    reg_id_t dst;
    data_t   src0_val;
    data_t   src1_val;
    imm_t    imm;

    modport src  (output alu_vld, mul_vld, op, dst, src0_val, src1_val, imm);
    modport sink (input  alu_vld, mul_vld, op, dst, src0_val, src1_val, imm);
endinterface

// Two independent register write ports, one per execution unit
interface wb_if;
    import scoreboard_cpu_pkg::*;

    logic    alu_vld;
    reg_id_t alu_reg;
    data_t   alu_data;
    logic    mul_vld;
    reg_id_t mul_reg;
    data_t   mul_data;

    modport src  (output alu_vld, alu_reg, alu_data, mul_vld, mul_reg, mul_data);
    modport sink (input  alu_vld, alu_reg, alu_data, mul_vld, mul_reg, mul_data);
endinterface

interface store_if;
    import scoreboard_cpu_pkg::*;

    logic     push;
    inst_id_t id;
    data_t    addr;
    data_t    data;
    logic     full;

    modport src  (output push, id, addr, data, input  full);
    modport sink (input  push, id, addr, data, output full);
endinterface

`default_nettype wire

//--- fetch_ctrl.sv
`default_nettype none

module fetch_ctrl (
    input  logic                         clk,
    input  logic                         rst_n,

    output logic                         fetch_vld,
    input  logic                         fetch_rdy,
    output scoreboard_cpu_pkg::pc_t      fetch_pc,
    output scoreboard_cpu_pkg::inst_id_t fetch_id,

    input  logic                         inst_vld,
    input  logic                         inst_last,
    input  scoreboard_cpu_pkg::imm_t     inst_imm,

    input  logic                         inst_accept,
    input  logic                         br_taken,

    output logic                         last_issued
);
    import scoreboard_cpu_pkg::*;

    // Pc of the presented instruction, or the address still to be fetched
    // once the presented instruction has gone
    pc_t      pc_q;
    inst_id_t id_q;
    logic     req_wait;
    logic     fetch_xfer;

    assign fetch_xfer = fetch_vld && fetch_rdy;

    // Only one fetch is outstanding at a time
    assign fetch_vld = !last_issued &&
                       ((!req_wait && !inst_vld) || (inst_accept && !inst_last));

    always_comb begin
        if (inst_accept) begin
            fetch_pc = br_taken ? pc_t'(inst_imm) : pc_q + pc_t'(1);
        end else begin
            fetch_pc = pc_q;
        end
    end

    assign fetch_id = id_q;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pc_q     <= '0;
            id_q     <= '0;
            req_wait <= 1'b0;
        end else begin
            req_wait <= fetch_xfer;
            if (fetch_xfer || inst_accept) begin
                pc_q <= fetch_pc;
            end
            if (fetch_xfer) begin
                id_q <= id_q + inst_id_t'(1);
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            last_issued <= 1'b0;
        end else if (inst_accept && inst_last) begin
            last_issued <= 1'b1;
        end
    end

endmodule

`default_nettype wire

//--- issue_stage.sv
`default_nettype none

module issue_stage (
    input  logic                         clk,
    input  logic                         rst_n,

    input  logic                         inst_vld,
    output logic                         inst_rdy,
    input  scoreboard_cpu_pkg::op_t      inst_op,
    input  scoreboard_cpu_pkg::inst_id_t inst_id,
    input  scoreboard_cpu_pkg::reg_id_t  inst_dst,
    input  scoreboard_cpu_pkg::reg_id_t  inst_src0,
    input  scoreboard_cpu_pkg::reg_id_t  inst_src1,
    input  scoreboard_cpu_pkg::imm_t     inst_imm,

    output logic                         inst_accept,
    output logic                         br_taken,

    output scoreboard_cpu_pkg::reg_id_t  rd_addr0,
    output scoreboard_cpu_pkg::reg_id_t  rd_addr1,
    input  scoreboard_cpu_pkg::data_t    rd_data0,
    input  scoreboard_cpu_pkg::data_t    rd_data1,

    issue_if.src                         iss,
    wb_if.sink                           wb,
    store_if.src                         st,

    output logic                         none_pending
);
    import scoreboard_cpu_pkg::*;

    reg_mask_t pend_q;
    reg_mask_t set_mask;
    reg_mask_t clr_mask;
    logic      is_alu;
    logic      is_mul;
    logic      is_st;
    logic      is_bz;
    logic      writes_dst;
    logic      use_src1;
    logic      hazard;

    assign is_alu = inst_op inside {OP_CMP_GT, OP_ADD_IMM, OP_ADD, OP_SHL, OP_SHR};
    assign is_mul = (inst_op == OP_MUL);
    assign is_st  = (inst_op == OP_ST);
    assign is_bz  = (inst_op == OP_BZ);

    assign writes_dst = is_alu || is_mul;
    assign use_src1   = !(inst_op == OP_ADD_IMM || is_bz);

    // A BZ waits here until its condition register has been written back
    assign hazard = pend_q[inst_src0] ||
                    (use_src1 && pend_q[inst_src1]) ||
                    (writes_dst && pend_q[inst_dst]) ||
                    (is_st && st.full);

    assign inst_accept = inst_vld && !hazard;
    assign inst_rdy    = inst_accept;
    assign br_taken    = inst_accept && is_bz && (rd_data0 == '0);

    assign rd_addr0 = inst_src0;
    assign rd_addr1 = inst_src1;

    assign iss.alu_vld  = inst_accept && is_alu;
    assign iss.mul_vld  = inst_accept && is_mul;
    assign iss.op       = inst_op;
    assign iss.dst      = inst_dst;
    assign iss.src0_val = rd_data0;
    assign iss.src1_val = rd_data1;
    assign iss.imm      = inst_imm;

    assign st.push = inst_accept && is_st;
    assign st.id   = inst_id;
    assign st.addr = rd_data0 + data_t'(inst_imm);
    assign st.data = rd_data1;

    always_comb begin
        set_mask = '0;
        clr_mask = '0;
        if (inst_accept && writes_dst) begin
            set_mask[inst_dst] = 1'b1;
        end
        if (wb.alu_vld) begin
            clr_mask[wb.alu_reg] = 1'b1;
        end
        if (wb.mul_vld) begin
            clr_mask[wb.mul_reg] = 1'b1;
        end
    end

    // A new issue to a register wins over a writeback clearing it in the same cycle
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pend_q <= '0;
        end else begin
            pend_q <= (pend_q & ~clr_mask) | set_mask;
        end
    end

    assign none_pending = (pend_q == '0);

    // Every result coming back from the units belongs to a pending register
    a_wb_was_pending : assert property (@(posedge clk) disable iff (!rst_n)
        (wb.alu_vld |-> pend_q[wb.alu_reg]) and (wb.mul_vld |-> pend_q[wb.mul_reg]));

endmodule

`default_nettype wire

//--- reg_file.sv
`default_nettype none

module reg_file (
    input  logic                        clk,
    input  logic                        rst_n,

    input  scoreboard_cpu_pkg::reg_id_t rd_addr0,
    input  scoreboard_cpu_pkg::reg_id_t rd_addr1,
    output scoreboard_cpu_pkg::data_t   rd_data0,
    output scoreboard_cpu_pkg::data_t   rd_data1,

    wb_if.sink                          wb
);
    import scoreboard_cpu_pkg::*;

    data_t regs [NUM_REG];

    // Reads are combinational so operands are ready in the issue cycle
    assign rd_data0 = regs[rd_addr0];
    assign rd_data1 = regs[rd_addr1];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < NUM_REG; i++) begin
                regs[i] <= '0;
            end
        end else begin
            if (wb.alu_vld) begin
                regs[wb.alu_reg] <= wb.alu_data;
            end
            if (wb.mul_vld) begin
                regs[wb.mul_reg] <= wb.mul_data;
            end
        end
    end

    a_no_write_collision : assert property (@(posedge clk) disable iff (!rst_n)
        !(wb.alu_vld && wb.mul_vld && (wb.alu_reg == wb.mul_reg)));

endmodule

`default_nettype wire

//--- exec_units.sv
`default_nettype none

module exec_units (
    input  logic clk,
    input  logic rst_n,

    issue_if.sink iss,
    wb_if.src     wb
);
    import scoreboard_cpu_pkg::*;

    data_t   alu_res;
    data_t   mul_prod;

    logic    alu_vld_q;
    reg_id_t alu_reg_q;
    data_t   alu_data_q;

    logic [MUL_STAGES-1:0] mul_vld_q;
    reg_id_t               mul_reg_q  [MUL_STAGES];
    data_t                 mul_data_q [MUL_STAGES];

    always_comb begin
        case (iss.op)
            OP_CMP_GT:  alu_res = data_t'(iss.src0_val > iss.src1_val);
            OP_ADD_IMM: alu_res = iss.src0_val + data_t'(iss.imm);
            OP_ADD:     alu_res = iss.src0_val + iss.src1_val;
            OP_SHL:     alu_res = iss.src0_val << iss.src1_val[3:0];
            OP_SHR:     alu_res = iss.src0_val >> iss.src1_val[3:0];
            default:    alu_res = '0;
        endcase
    end

    // Low half of the product only
    assign mul_prod = iss.src0_val * iss.src1_val;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            alu_vld_q <= 1'b0;
            mul_vld_q <= '0;
        end else begin
            alu_vld_q <= iss.alu_vld;
            mul_vld_q <= {mul_vld_q[MUL_STAGES-2:0], iss.mul_vld};
        end
    end

    always_ff @(posedge clk) begin
        if (iss.alu_vld) begin
            alu_reg_q  <= iss.dst;
            alu_data_q <= alu_res;
        end
    end

    // The product is formed in the first stage and then carried along
    always_ff @(posedge clk) begin
        mul_reg_q[0]  <= iss.dst;
        mul_data_q[0] <= mul_prod;
        for (int s = 1; s < MUL_STAGES; s++) begin
            mul_reg_q[s]  <= mul_reg_q[s-1];
            mul_data_q[s] <= mul_data_q[s-1];
        end
    end

    assign wb.alu_vld  = alu_vld_q;
    assign wb.alu_reg  = alu_reg_q;
    assign wb.alu_data = alu_data_q;

    assign wb.mul_vld  = mul_vld_q[MUL_STAGES-1];
    assign wb.mul_reg  = mul_reg_q[MUL_STAGES-1];
    assign wb.mul_data = mul_data_q[MUL_STAGES-1];

endmodule

`default_nettype wire

//--- store_queue.sv
`default_nettype none

module store_queue (
    input  logic                         clk,
    input  logic                         rst_n,

    store_if.sink                        st,

    output logic                         write_mem_vld,
    input  logic                         write_mem_rdy,
    output scoreboard_cpu_pkg::inst_id_t write_mem_id,
    output scoreboard_cpu_pkg::data_t    write_mem_addr,
    output scoreboard_cpu_pkg::data_t    write_mem_data,

    output logic                         empty
);
    import scoreboard_cpu_pkg::*;

    inst_id_t id_mem   [STORE_DEPTH];
    data_t    addr_mem [STORE_DEPTH];
    data_t    data_mem [STORE_DEPTH];

    logic [SQ_PTR_W-1:0] wr_ptr;
    logic [SQ_PTR_W-1:0] rd_ptr;
    logic [SQ_CNT_W-1:0] count;
    logic                pop;

    assign pop = write_mem_vld && write_mem_rdy;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (st.push) begin
                wr_ptr <= (wr_ptr == SQ_PTR_W'(STORE_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == SQ_PTR_W'(STORE_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            if (st.push && !pop) begin
                count <= count + 1'b1;
            end else if (pop && !st.push) begin
                count <= count - 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (st.push) begin
            id_mem[wr_ptr]   <= st.id;
            addr_mem[wr_ptr] <= st.addr;
            data_mem[wr_ptr] <= st.data;
        end
    end

    assign st.full = (count == SQ_CNT_W'(STORE_DEPTH));
    assign empty   = (count == '0);

    // Head entry drives the memory port directly
    assign write_mem_vld  = !empty;
    assign write_mem_id   = id_mem[rd_ptr];
    assign write_mem_addr = addr_mem[rd_ptr];
    assign write_mem_data = data_mem[rd_ptr];

    a_no_push_when_full : assert property (@(posedge clk) disable iff (!rst_n)
        st.push |-> !st.full);

    a_held_under_backpressure : assert property (@(posedge clk) disable iff (!rst_n)
        (write_mem_vld && !write_mem_rdy) |=>
            (write_mem_vld && $stable(write_mem_id) && $stable(write_mem_addr) &&
             $stable(write_mem_data)));

endmodule

`default_nettype wire

//--- scoreboard_cpu.sv
`default_nettype none

module scoreboard_cpu (
    input  logic                         clk,
    input  logic                         rst_n,

    output logic                         fetch_vld,
    input  logic                         fetch_rdy,
    output scoreboard_cpu_pkg::pc_t      fetch_pc,
    output scoreboard_cpu_pkg::inst_id_t fetch_id,

    input  logic                         inst_vld,
    output logic                         inst_rdy,
    input  scoreboard_cpu_pkg::op_t      inst_op,
    input  scoreboard_cpu_pkg::inst_id_t inst_id,
    input  scoreboard_cpu_pkg::reg_id_t  inst_dst,
    input  scoreboard_cpu_pkg::reg_id_t  inst_src0,
    input  scoreboard_cpu_pkg::reg_id_t  inst_src1,
    input  scoreboard_cpu_pkg::imm_t     inst_imm,
    input  logic                         inst_last,

    output logic                         write_mem_vld,
    input  logic                         write_mem_rdy,
    output scoreboard_cpu_pkg::inst_id_t write_mem_id,
    output scoreboard_cpu_pkg::data_t    write_mem_addr,
    output scoreboard_cpu_pkg::data_t    write_mem_data,

    output logic                         exec_finish
);
    import scoreboard_cpu_pkg::*;

    logic    inst_accept;
    logic    br_taken;
    logic    last_issued;
    logic    none_pending;
    logic    sq_empty;
    reg_id_t rd_addr0;
    reg_id_t rd_addr1;
    data_t   rd_data0;
    data_t   rd_data1;

    issue_if iss_bus ();
    wb_if    wb_bus ();
    store_if st_bus ();

    fetch_ctrl u_fetch (
        .clk         (clk),
        .rst_n       (rst_n),
        .fetch_vld   (fetch_vld),
        .fetch_rdy   (fetch_rdy),
        .fetch_pc    (fetch_pc),
        .fetch_id    (fetch_id),
        .inst_vld    (inst_vld),
        .inst_last   (inst_last),
        .inst_imm    (inst_imm),
        .inst_accept (inst_accept),
        .br_taken    (br_taken),
        .last_issued (last_issued)
    );

    issue_stage u_issue (
        .clk          (clk),
        .rst_n        (rst_n),
        .inst_vld     (inst_vld),
        .inst_rdy     (inst_rdy),
        .inst_op      (inst_op),
        .inst_id      (inst_id),
        .inst_dst     (inst_dst),
        .inst_src0    (inst_src0),
        .inst_src1    (inst_src1),
        .inst_imm     (inst_imm),
        .inst_accept  (inst_accept),
        .br_taken     (br_taken),
        .rd_addr0     (rd_addr0),
        .rd_addr1     (rd_addr1),
        .rd_data0     (rd_data0),
        .rd_data1     (rd_data1),
        .iss          (iss_bus.src),
        .wb           (wb_bus.sink),
        .st           (st_bus.src),
        .none_pending (none_pending)
    );

    reg_file u_rf (
        .clk      (clk),
        .rst_n    (rst_n),
        .rd_addr0 (rd_addr0),
        .rd_addr1 (rd_addr1),
        .rd_data0 (rd_data0),
        .rd_data1 (rd_data1),
        .wb       (wb_bus.sink)
    );

    exec_units u_exec (
        .clk   (clk),
        .rst_n (rst_n),
        .iss   (iss_bus.sink),
        .wb    (wb_bus.src)
    );

    store_queue u_sq (
        .clk            (clk),
        .rst_n          (rst_n),
        .st             (st_bus.sink),
        .write_mem_vld  (write_mem_vld),
        .write_mem_rdy  (write_mem_rdy),
        .write_mem_id   (write_mem_id),
        .write_mem_addr (write_mem_addr),
        .write_mem_data (write_mem_data),
        .empty          (sq_empty)
    );

    // Nothing can be issued after the last instruction, so this stays high once set
    assign exec_finish = last_issued && none_pending && sq_empty;

endmodule

`default_nettype wire

//--- tb_scoreboard_cpu.sv
`default_nettype none

module tb_scoreboard_cpu;
    timeunit 1ns;
    timeprecision 1ns;

    import scoreboard_cpu_pkg::*;

    localparam int SEED           = 71886;
    localparam int PROG_WORDS     = 32;
    localparam int RDY_ADDR       = 32;
    localparam int CNT_ADDR       = 33;
    localparam int STORE_BASE     = 40;
    localparam int PAT_WORDS      = 64;
    localparam int RESET_CYCLES   = 8;
    localparam int FINISH_TIMEOUT = 2000;
    localparam int DRAIN_CYCLES   = 20;

    logic     clk           = 1'b0;
    logic     rst_n         = 1'b0;
    logic     fetch_vld;
    logic     fetch_rdy     = 1'b0;
    pc_t      fetch_pc;
    inst_id_t fetch_id;
    logic     inst_vld      = 1'b0;
    logic     inst_rdy;
    op_t      inst_op       = OP_ST;
    inst_id_t inst_id       = '0;
    reg_id_t  inst_dst      = '0;
    reg_id_t  inst_src0     = '0;
    reg_id_t  inst_src1     = '0;
    imm_t     inst_imm      = '0;
    logic     inst_last     = 1'b0;
    logic     write_mem_vld;
    logic     write_mem_rdy = 1'b0;
    inst_id_t write_mem_id;
    data_t    write_mem_addr;
    data_t    write_mem_data;
    logic     exec_finish;

    // Program at 0x00, ready pattern at 0x20, store count at 0x21, stores from 0x28
    logic [39:0] pat_mem [PAT_WORDS];
    logic [31:0] rdy_pat;
    logic [4:0]  pat_idx    = '0;
    logic [39:0] rec;
    int          exp_cnt;
    int          store_cnt  = 0;
    int          wait_cycles;
    logic        hold_q     = 1'b0;
    inst_id_t    held_id;
    data_t       held_addr;
    data_t       held_data;

    int data_errs  = 0;
    int id_errs    = 0;
    int pc_errs    = 0;
    int flag_errs  = 0;
    int count_errs = 0;
    int other_errs = 0;

    scoreboard_cpu u_dut (
        .clk            (clk),
        .rst_n          (rst_n),
        .fetch_vld      (fetch_vld),
        .fetch_rdy      (fetch_rdy),
        .fetch_pc       (fetch_pc),
        .fetch_id       (fetch_id),
        .inst_vld       (inst_vld),
        .inst_rdy       (inst_rdy),
        .inst_op        (inst_op),
        .inst_id        (inst_id),
        .inst_dst       (inst_dst),
        .inst_src0      (inst_src0),
        .inst_src1      (inst_src1),
        .inst_imm       (inst_imm),
        .inst_last      (inst_last),
        .write_mem_vld  (write_mem_vld),
        .write_mem_rdy  (write_mem_rdy),
        .write_mem_id   (write_mem_id),
        .write_mem_addr (write_mem_addr),
        .write_mem_data (write_mem_data),
        .exec_finish    (exec_finish)
    );

    initial begin
        forever #50 clk = ~clk;
    end

    task automatic check_data(input string name, input data_t got, input data_t exp);
        if (got !== exp) begin
            data_errs++;
            $display("[ERROR] %0t %s: got %h, expected %h", $time, name, got, exp);
        end
    endtask

    task automatic check_id(input string name, input inst_id_t got, input inst_id_t exp);
        if (got !== exp) begin
            id_errs++;
            $display("[ERROR] %0t %s: got %h, expected %h", $time, name, got, exp);
        end
    endtask

    task automatic check_pc(input string name, input pc_t got, input pc_t exp);
        if (got !== exp) begin
            pc_errs++;
            $display("[ERROR] %0t %s: got %h, expected %h", $time, name, got, exp);
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            flag_errs++;
            $display("[ERROR] %0t %s: got %b, expected %b", $time, name, got, exp);
        end
    endtask

    task automatic check_count(input string name, input int got, input int exp);
        if (got != exp) begin
            count_errs++;
            $display("[ERROR] %0t %s: got %0d, expected %0d", $time, name, got, exp);
        end
    endtask

    // Instruction memory answers a fetch on the following cycle
    task automatic present_inst(input pc_t pc, input inst_id_t id);
        logic [39:0] word;
        if (pc >= pc_t'(PROG_WORDS)) begin
            other_errs++;
            $display("Fetch at %0t from pc %0d lies outside the program", $time, pc);
        end else begin
            word = pat_mem[pc[5:0]];
            inst_vld  <= 1'b1;
            inst_id   <= id;
            inst_op   <= op_t'(word[26:24]);
            inst_dst  <= word[23:20];
            inst_src0 <= word[19:16];
            inst_src1 <= word[15:12];
            inst_imm  <= word[11:4];
            inst_last <= word[0];
        end
    endtask

    always @(posedge clk) begin
        if (rst_n) begin
            fetch_rdy     <= ($urandom % 4) != 0;
            write_mem_rdy <= rdy_pat[pat_idx];
            pat_idx       <= pat_idx + 1'b1;
            if (inst_vld && inst_rdy) begin
                inst_vld <= 1'b0;
            end
            if (fetch_vld && fetch_rdy) begin
                if (inst_vld && !inst_rdy) begin
                    other_errs++;
                    $display("Fetch at %0t while an instruction is still waiting", $time);
                end
                present_inst(fetch_pc, fetch_id);
            end
        end
    end

    // Store monitor
    always @(posedge clk) begin
        if (rst_n) begin
            if (hold_q) begin
                if (!write_mem_vld) begin
                    other_errs++;
                    $display("write_mem_vld dropped at %0t before the transfer", $time);
                end
                check_id("write_mem_id held", write_mem_id, held_id);
                check_data("write_mem_addr held", write_mem_addr, held_addr);
                check_data("write_mem_data held", write_mem_data, held_data);
            end
            if (write_mem_vld && write_mem_rdy) begin
                if (store_cnt < exp_cnt) begin
                    rec = pat_mem[6'(STORE_BASE + store_cnt)];
                    check_id("write_mem_id", write_mem_id, rec[39:32]);
                    check_data("write_mem_addr", write_mem_addr, rec[31:16]);
                    check_data("write_mem_data", write_mem_data, rec[15:0]);
                end else begin
                    other_errs++;
                    $display("Extra store with id %0d at %0t", write_mem_id, $time);
                end
                store_cnt++;
            end
            hold_q    = write_mem_vld && !write_mem_rdy;
            held_id   = write_mem_id;
            held_addr = write_mem_addr;
            held_data = write_mem_data;
        end
    end

    initial begin
        void'($urandom(SEED));
        $readmemh("scoreboard_cpu_patterns.mem", pat_mem);
        rdy_pat = pat_mem[RDY_ADDR][31:0];
        exp_cnt = int'(pat_mem[CNT_ADDR][7:0]);

        repeat (RESET_CYCLES) @(posedge clk);
        rst_n <= 1'b1;
        @(posedge clk);
        check_bit("fetch_vld", fetch_vld, 1'b1);
        check_pc("fetch_pc", fetch_pc, '0);
        check_id("fetch_id", fetch_id, '0);
        check_bit("inst_rdy", inst_rdy, 1'b0);
        check_bit("write_mem_vld", write_mem_vld, 1'b0);
        check_bit("exec_finish", exec_finish, 1'b0);

        wait_cycles = 0;
        while (!exec_finish && wait_cycles < FINISH_TIMEOUT) begin
            @(posedge clk);
            wait_cycles++;
        end

        if (!exec_finish) begin
            other_errs++;
            $display("exec_finish did not rise within %0d cycles", FINISH_TIMEOUT);
        end else begin
            check_count("stores at exec_finish", store_cnt, exp_cnt);
            // No store may follow the end of the program
            repeat (DRAIN_CYCLES) @(posedge clk);
            @(negedge clk);
            check_bit("exec_finish", exec_finish, 1'b1);
            check_count("stores", store_cnt, exp_cnt);
        end

        $display("Errors: data %0d, id %0d, pc %0d, flag %0d, count %0d, other %0d",
                 data_errs, id_errs, pc_errs, flag_errs, count_errs, other_errs);
        if (data_errs + id_errs + pc_errs + flag_errs + count_errs + other_errs == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- scoreboard_cpu_patterns.mem
// Program at 00: one hex digit each for op, dst, src0, src1, two for imm, one for last
// 20: write_mem_rdy pattern, bit n used on cycle n mod 32; 21: number of stores
// 28: expected stores as id (2 digits), addr (4 digits), data (4 digits)
@00
2100050  // r1 = 5
2200030  // r2 = 3
6312000  // r3 = r1 * r2
4512000  // r5 = r1 << r2, written back before the multiply
3431000  // r4 = r3 + r1 waits for the multiply
5652000
0004100
0005110
0016200
2770010  // loop: r7 = r7 + 1
0077300
1872000  // r8 = r7 > r2
7080090  // back to 09 while r8 is zero
70000f0  // always taken, skips the next store
0001400
0003501
@20
0F00F03C
@21
8
@28
0600100014
0700110028
0800250005
0a00310001
0e00320002
1200330003
1600340004
1a0050000f

//--- scoreboard_cpu.f
scoreboard_cpu_pkg.sv
scoreboard_cpu_if.sv
fetch_ctrl.sv
issue_stage.sv
reg_file.sv
exec_units.sv
store_queue.sv
scoreboard_cpu.sv
tb_scoreboard_cpu.sv

//--- Makefile
VERILATOR := verilator
VFLAGS    := --binary --timing --assert
TOP       := tb_scoreboard_cpu
FILELIST  := scoreboard_cpu.f
OBJ_DIR   := obj_dir
LOG       := sim.log
FAIL_MSG  := Testbench failed

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: compile
	@./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "Simulation failed, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
